// ==== slurm16_defs.svh ====
// widths and reset address shared by the slurm16 core; include before using the macros
`ifndef SLURM16_DEFS_SVH
`define SLURM16_DEFS_SVH

// data path and instruction word width
`define SLURM16_BITS 16

// register file size and select width
`define SLURM16_REGS 16
`define SLURM16_REG_BITS 4

// immediate field in the low byte of the word
`define SLURM16_IMM_BITS 8

// port address comes from imm8
`define SLURM16_PORT_BITS 8

// first fetch address after reset
`define SLURM16_RESET_PC 16'h0000

`endif

// ==== slurm16_pkg.sv ====
// opcode enum and pipeline payload structs of the slurm16 core, referenced by scoped names
`default_nettype none

`include "slurm16_defs.svh"

package slurm16_pkg;

	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_MOVI = 4'h6,
		OP_ADDI = 4'h7,
		OP_OUT  = 4'h8,
		OP_BZ   = 4'h9,
		OP_JMP  = 4'ha,
		OP_HALT = 4'hb
	} opcode_e;

	// imm8 overlays ra and rb
	typedef struct packed {
		opcode_e                       opcode;
		logic [`SLURM16_REG_BITS-1:0] rd;
		logic [`SLURM16_REG_BITS-1:0] ra;
		logic [`SLURM16_REG_BITS-1:0] rb;
	} instr_t;

	typedef struct packed {
		logic [`SLURM16_BITS-1:0] pc;
		instr_t                   instr;
	} fd_t;

	typedef struct packed {
		logic [`SLURM16_BITS-1:0]     pc;
		opcode_e                      opcode;
		logic [`SLURM16_REG_BITS-1:0] rd;
		logic [`SLURM16_BITS-1:0]     a;
		logic [`SLURM16_BITS-1:0]     b;
		logic [`SLURM16_BITS-1:0]     rd_value;
		logic [`SLURM16_IMM_BITS-1:0] imm8;
		logic                         writes_reg;
		logic                         sets_flags;
	} de_t;

	typedef struct packed {
		logic [`SLURM16_REG_BITS-1:0]  rd;
		logic [`SLURM16_BITS-1:0]      result;
		logic                          writes_reg;
		logic                          port_wr;
		logic [`SLURM16_PORT_BITS-1:0] port_address;
		logic [`SLURM16_BITS-1:0]      port_data;
	} ew_t;

endpackage

`default_nettype wire

// ==== slurm16_stage_reg.sv ====
// pipeline register that sits between each pair of stages and holds on stall and empties on flush
`timescale 1ns/1ps
`default_nettype none

module slurm16_stage_reg #(
	parameter type payload_t = logic [15:0]
) (
	input  wire      CLK,
	input  wire      arst_n,
	input  wire      in_valid,
	input  payload_t in_data,
	input  wire      stall,
	input  wire      flush,
	output logic     out_valid,
	output payload_t out_data
);

	// flush has priority over stall
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else if (flush) begin
			out_valid <= 1'b0;
		end else if (!stall) begin
			out_valid <= in_valid;
		end
	end

	// payload moves with the valid bit
	always_ff @(posedge CLK) begin
		if (!stall) begin
			out_data <= in_data;
		end
	end

	valid_known: assert property (
		@(posedge CLK) disable iff (!arst_n)
		!$isunknown(out_valid)
	);

endmodule

`default_nettype wire

// ==== slurm16_fetch.sv ====
// fetch stage of the cpu top with the pc and one outstanding request and a one-word return buffer
`timescale 1ns/1ps
`default_nettype none

`include "slurm16_defs.svh"

module slurm16_fetch (
	input  wire                     CLK,
	input  wire                     arst_n,
	output logic                    instruction_request,
	output logic [`SLURM16_BITS-1:0] instruction_address,
	input  wire                     instruction_valid,
	input  wire [`SLURM16_BITS-1:0] instruction_data,
	input  wire                     stall,
	input  wire                     branch_taken,
	input  wire [`SLURM16_BITS-1:0] branch_target,
	input  wire                     halted,
	output logic                    fd_valid,
	output slurm16_pkg::fd_t        fd_data
);

	logic [`SLURM16_BITS-1:0] pc;
	logic                     outstanding;
	logic                     stale;
	logic                     buf_valid;
	slurm16_pkg::fd_t         buf_data;
	slurm16_pkg::fd_t         fresh;
	logic                     ret;
	logic                     take;

	// a return is usable unless a redirect or halt has overtaken it
	assign ret  = instruction_valid && outstanding && !stale && !halted && !branch_taken;
	assign take = !stall;

	// no request while in reset
	assign instruction_request = arst_n && !outstanding && !buf_valid && !halted &&
		!branch_taken;
	assign instruction_address = pc;

	always_comb begin
		fresh.pc    = pc;
		fresh.instr = slurm16_pkg::instr_t'(instruction_data);
	end

	assign fd_valid = buf_valid || ret;
	assign fd_data  = buf_valid ? buf_data : fresh;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			pc          <= `SLURM16_RESET_PC;
			outstanding <= 1'b0;
			stale       <= 1'b0;
			buf_valid   <= 1'b0;
		end else begin
			if (instruction_request)
				outstanding <= 1'b1;
			else if (instruction_valid)
				outstanding <= 1'b0;

			// a request in flight across a redirect returns the wrong word
			if (branch_taken && outstanding && !instruction_valid)
				stale <= 1'b1;
			else if (instruction_valid)
				stale <= 1'b0;

			if (branch_taken)
				pc <= branch_target;
			else if (ret)
				pc <= pc + 1'b1;

			if (branch_taken)
				buf_valid <= 1'b0;
			else if (buf_valid && take)
				buf_valid <= 1'b0;
			else if (ret && !take)
				buf_valid <= 1'b1;
		end
	end

	// park the word while decode is busy
	always_ff @(posedge CLK) begin
		if (ret && !take)
			buf_data <= fresh;
	end

	return_has_request: assert property (
		@(posedge CLK) disable iff (!arst_n)
		instruction_valid |-> outstanding
	);

endmodule

`default_nettype wire

// ==== slurm16_registers.sv ====
// register file, three asynchronous read ports and one synchronous write port
`timescale 1ns/1ps
`default_nettype none

`include "slurm16_defs.svh"

module slurm16_registers (
	input  wire                         CLK,
	input  wire                         arst_n,
	input  wire [`SLURM16_REG_BITS-1:0] ra_sel,
	input  wire [`SLURM16_REG_BITS-1:0] rb_sel,
	input  wire [`SLURM16_REG_BITS-1:0] rd_sel,
	output logic [`SLURM16_BITS-1:0]    ra_data,
	output logic [`SLURM16_BITS-1:0]    rb_data,
	output logic [`SLURM16_BITS-1:0]    rd_data,
	input  wire                         wr_en,
	input  wire [`SLURM16_REG_BITS-1:0] wr_sel,
	input  wire [`SLURM16_BITS-1:0]     wr_data
);

	logic [`SLURM16_BITS-1:0] regs [`SLURM16_REGS];

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `SLURM16_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_sel] <= wr_data;
		end
	end

	// rd port serves OUT and ADDI
	assign ra_data = regs[ra_sel];
	assign rb_data = regs[rb_sel];
	assign rd_data = regs[rd_sel];

endmodule

`default_nettype wire

// ==== slurm16_decode.sv ====
// decode stage: field split, register read and source reporting for the hazard unit
`timescale 1ns/1ps
`default_nettype none

`include "slurm16_defs.svh"

module slurm16_decode (
	input  wire                          CLK,
	input  wire                          arst_n,
	input  wire                          fd_valid,
	input  slurm16_pkg::fd_t             fd_data,
	output logic                         de_valid,
	output slurm16_pkg::de_t             de_data,
	output logic                         use_a,
	output logic                         use_b,
	output logic                         use_rd,
	output logic                         use_flags,
	output logic [`SLURM16_REG_BITS-1:0] src_a,
	output logic [`SLURM16_REG_BITS-1:0] src_b,
	output logic [`SLURM16_REG_BITS-1:0] src_rd,
	input  wire                          wr_en,
	input  wire [`SLURM16_REG_BITS-1:0]  wr_sel,
	input  wire [`SLURM16_BITS-1:0]      wr_data
);

	logic [`SLURM16_BITS-1:0] ra_data;
	logic [`SLURM16_BITS-1:0] rb_data;
	logic [`SLURM16_BITS-1:0] rd_data;
	slurm16_pkg::opcode_e     op;
	logic                     alu_op;

	assign op    = fd_data.instr.opcode;
	assign src_a  = fd_data.instr.ra;
	assign src_b  = fd_data.instr.rb;
	assign src_rd = fd_data.instr.rd;

	slurm16_registers u_registers (
		.CLK     (CLK),
		.arst_n  (arst_n),
		.ra_sel  (src_a),
		.rb_sel  (src_b),
		.rd_sel  (src_rd),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.rd_data (rd_data),
		.wr_en   (wr_en),
		.wr_sel  (wr_sel),
		.wr_data (wr_data)
	);

	// two-register ALU forms
	assign alu_op = (op == slurm16_pkg::OP_ADD) || (op == slurm16_pkg::OP_SUB) ||
		(op == slurm16_pkg::OP_AND) || (op == slurm16_pkg::OP_OR) ||
		(op == slurm16_pkg::OP_XOR);

	assign use_a     = fd_valid && alu_op;
	assign use_b     = fd_valid && alu_op;
	assign use_rd    = fd_valid && (op == slurm16_pkg::OP_OUT || op == slurm16_pkg::OP_ADDI);
	assign use_flags = fd_valid && (op == slurm16_pkg::OP_BZ);

	assign de_valid = fd_valid;

	always_comb begin
		de_data.pc         = fd_data.pc;
		de_data.opcode     = op;
		de_data.rd         = fd_data.instr.rd;
		de_data.a          = ra_data;
		de_data.b          = rb_data;
		de_data.rd_value   = rd_data;
		de_data.imm8       = {fd_data.instr.ra, fd_data.instr.rb};
		de_data.writes_reg = alu_op || op == slurm16_pkg::OP_MOVI || op == slurm16_pkg::OP_ADDI;
		de_data.sets_flags = alu_op || op == slurm16_pkg::OP_ADDI;
	end

endmodule

`default_nettype wire

// ==== slurm16_hazard.sv ====
// hazard unit: stalls decode on register or flag dependencies, there is no forwarding
`timescale 1ns/1ps
`default_nettype none

`include "slurm16_defs.svh"

module slurm16_hazard (
	input  wire                         use_a,
	input  wire                         use_b,
	input  wire                         use_rd,
	input  wire                         use_flags,
	input  wire [`SLURM16_REG_BITS-1:0] src_a,
	input  wire [`SLURM16_REG_BITS-1:0] src_b,
	input  wire [`SLURM16_REG_BITS-1:0] src_rd,
	input  wire                         e_valid,
	input  slurm16_pkg::de_t            e_data,
	input  wire                         w_valid,
	input  slurm16_pkg::ew_t            w_data,
	output logic                        stall
);

	logic e_wr;
	logic w_wr;
	logic hit_a;
	logic hit_b;
	logic hit_rd;
	logic flag_hit;

	// live register writers in execute and writeback
	assign e_wr = e_valid && e_data.writes_reg;
	assign w_wr = w_valid && w_data.writes_reg;

	assign hit_a  = use_a && ((e_wr && e_data.rd == src_a) || (w_wr && w_data.rd == src_a));
	assign hit_b  = use_b && ((e_wr && e_data.rd == src_b) || (w_wr && w_data.rd == src_b));
	assign hit_rd = use_rd && ((e_wr && e_data.rd == src_rd) || (w_wr && w_data.rd == src_rd));

	// BZ waits for the flag setter to leave execute
	assign flag_hit = use_flags && e_valid && e_data.sets_flags;

	assign stall = hit_a || hit_b || hit_rd || flag_hit;

endmodule

`default_nettype wire

// ==== slurm16_execute.sv ====
// execute stage of the cpu top with the ALU and the Z and C flags and branch and halt control
`timescale 1ns/1ps
`default_nettype none

`include "slurm16_defs.svh"

module slurm16_execute (
	input  wire                      CLK,
	input  wire                      arst_n,
	input  wire                      de_valid,
	input  slurm16_pkg::de_t         de_data,
	output logic                     ew_valid,
	output slurm16_pkg::ew_t         ew_data,
	output logic                     flag_z,
	output logic                     branch_taken,
	output logic [`SLURM16_BITS-1:0] branch_target,
	output logic                     halted
);

	logic                     flag_c;
	logic                     exec_ok;
	logic [`SLURM16_BITS-1:0] imm_sext;
	logic [`SLURM16_BITS:0]   sum;
	logic [`SLURM16_BITS-1:0] result;
	logic                     carry;

	// nothing past HALT takes effect
	assign exec_ok  = de_valid && !halted;
	assign imm_sext = {{(`SLURM16_BITS - `SLURM16_IMM_BITS){de_data.imm8[7]}}, de_data.imm8};

	always_comb begin
		sum = '0;
		case (de_data.opcode)
			slurm16_pkg::OP_ADD:
				sum = {1'b0, de_data.a} + {1'b0, de_data.b};
			// carry out here means no borrow
			slurm16_pkg::OP_SUB:
				sum = {1'b0, de_data.a} + {1'b0, ~de_data.b} + 1'b1;
			slurm16_pkg::OP_AND:
				sum = {1'b0, de_data.a & de_data.b};
			slurm16_pkg::OP_OR:
				sum = {1'b0, de_data.a | de_data.b};
			slurm16_pkg::OP_XOR:
				sum = {1'b0, de_data.a ^ de_data.b};
			slurm16_pkg::OP_MOVI:
				sum = {1'b0, {(`SLURM16_BITS - `SLURM16_IMM_BITS){1'b0}}, de_data.imm8};
			slurm16_pkg::OP_ADDI:
				sum = {1'b0, de_data.rd_value} + {1'b0, imm_sext};
			default:
				sum = '0;
		endcase
	end

	assign result = sum[`SLURM16_BITS-1:0];
	assign carry  = sum[`SLURM16_BITS];

	// BZ and JMP share the relative target
	assign branch_target = de_data.pc + 1'b1 + imm_sext;
	assign branch_taken  = exec_ok && (de_data.opcode == slurm16_pkg::OP_JMP ||
		(de_data.opcode == slurm16_pkg::OP_BZ && flag_z));

	assign ew_valid = exec_ok;

	always_comb begin
		ew_data.rd           = de_data.rd;
		ew_data.result       = result;
		ew_data.writes_reg   = de_data.writes_reg;
		ew_data.port_wr      = de_data.opcode == slurm16_pkg::OP_OUT;
		ew_data.port_address = de_data.imm8;
		ew_data.port_data    = de_data.rd_value;
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			flag_z <= 1'b0;
			flag_c <= 1'b0;
			halted <= 1'b0;
		end else begin
			if (exec_ok && de_data.sets_flags) begin
				flag_z <= result == '0;
				flag_c <= carry;
			end
			// sticky until reset
			if (exec_ok && de_data.opcode == slurm16_pkg::OP_HALT)
				halted <= 1'b1;
		end
	end

	// the core empties de once halted so no branch can follow
	flushed_after_halt: assert property (
		@(posedge CLK) disable iff (!arst_n)
		halted |=> !de_valid
	);

endmodule

`default_nettype wire

// ==== slurm16_cpu_top.sv ====
// top level of the slurm16 core, connects the stages to instruction memory and the port
`timescale 1ns/1ps
`default_nettype none

`include "slurm16_defs.svh"

module slurm16_cpu_top (
	input  wire                       CLK,
	input  wire                       arst_n,
	output logic                      instruction_request,
	output logic [`SLURM16_BITS-1:0]  instruction_address,
	input  wire                       instruction_valid,
	input  wire [`SLURM16_BITS-1:0]   instruction_data,
	output logic                      port_wr,
	output logic [`SLURM16_PORT_BITS-1:0] port_address,
	output logic [`SLURM16_BITS-1:0]  port_data,
	output logic                      halted
);

	logic                         f_valid;
	slurm16_pkg::fd_t             f_data;
	logic                         fd_valid;
	slurm16_pkg::fd_t             fd_q;
	logic                         d_valid;
	slurm16_pkg::de_t             d_data;
	logic                         de_valid;
	slurm16_pkg::de_t             de_q;
	logic                         x_valid;
	slurm16_pkg::ew_t             x_data;
	logic                         ew_valid;
	slurm16_pkg::ew_t             ew_q;
	logic                         use_a;
	logic                         use_b;
	logic                         use_rd;
	logic                         use_flags;
	logic [`SLURM16_REG_BITS-1:0] src_a;
	logic [`SLURM16_REG_BITS-1:0] src_b;
	logic [`SLURM16_REG_BITS-1:0] src_rd;
	logic                         stall;
	logic                         branch_taken;
	logic [`SLURM16_BITS-1:0]     branch_target;
	logic                         flush;
	logic                         reg_wr;

	// redirect or halt empties fd and de
	assign flush  = branch_taken || halted;
	assign reg_wr = ew_valid && ew_q.writes_reg;

	slurm16_fetch u_fetch (
		.CLK                 (CLK),
		.arst_n              (arst_n),
		.instruction_request (instruction_request),
		.instruction_address (instruction_address),
		.instruction_valid   (instruction_valid),
		.instruction_data    (instruction_data),
		.stall               (stall),
		.branch_taken        (branch_taken),
		.branch_target       (branch_target),
		.halted              (halted),
		.fd_valid            (f_valid),
		.fd_data             (f_data)
	);

	slurm16_stage_reg #(.payload_t(slurm16_pkg::fd_t)) u_fd_reg (
		.CLK       (CLK),
		.arst_n    (arst_n),
		.in_valid  (f_valid),
		.in_data   (f_data),
		.stall     (stall),
		.flush     (flush),
		.out_valid (fd_valid),
		.out_data  (fd_q)
	);

	slurm16_decode u_decode (
		.CLK       (CLK),
		.arst_n    (arst_n),
		.fd_valid  (fd_valid),
		.fd_data   (fd_q),
		.de_valid  (d_valid),
		.de_data   (d_data),
		.use_a     (use_a),
		.use_b     (use_b),
		.use_rd    (use_rd),
		.use_flags (use_flags),
		.src_a     (src_a),
		.src_b     (src_b),
		.src_rd    (src_rd),
		.wr_en     (reg_wr),
		.wr_sel    (ew_q.rd),
		.wr_data   (ew_q.result)
	);

	slurm16_hazard u_hazard (
		.use_a     (use_a),
		.use_b     (use_b),
		.use_rd    (use_rd),
		.use_flags (use_flags),
		.src_a     (src_a),
		.src_b     (src_b),
		.src_rd    (src_rd),
		.e_valid   (de_valid),
		.e_data    (de_q),
		.w_valid   (ew_valid),
		.w_data    (ew_q),
		.stall     (stall)
	);

	// a stalled decode sends a bubble forward
	slurm16_stage_reg #(.payload_t(slurm16_pkg::de_t)) u_de_reg (
		.CLK       (CLK),
		.arst_n    (arst_n),
		.in_valid  (d_valid && !stall),
		.in_data   (d_data),
		.stall     (1'b0),
		.flush     (flush),
		.out_valid (de_valid),
		.out_data  (de_q)
	);

	slurm16_execute u_execute (
		.CLK           (CLK),
		.arst_n        (arst_n),
		.de_valid      (de_valid),
		.de_data       (de_q),
		.ew_valid      (x_valid),
		.ew_data       (x_data),
		.flag_z        (),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.halted        (halted)
	);

	slurm16_stage_reg #(.payload_t(slurm16_pkg::ew_t)) u_ew_reg (
		.CLK       (CLK),
		.arst_n    (arst_n),
		.in_valid  (x_valid),
		.in_data   (x_data),
		.stall     (1'b0),
		.flush     (1'b0),
		.out_valid (ew_valid),
		.out_data  (ew_q)
	);

	// ew register doubles as the registered port
	assign port_wr      = ew_valid && ew_q.port_wr;
	assign port_address = ew_q.port_address;
	assign port_data    = ew_q.port_data;

endmodule

`default_nettype wire

// ==== tb_slurm16_cpu.sv ====
// testbench that runs the cpu top against an ISA model with a random-latency instruction memory
`timescale 1ns/1ps
`default_nettype none

`include "slurm16_defs.svh"

module tb_slurm16_cpu;

	localparam int RESET_CYCLES = 4;
	localparam int FIXED_WORDS = 22;
	localparam int RANDOM_WORDS = 24;
	localparam int PROG_WORDS = FIXED_WORDS + RANDOM_WORDS + 1;
	localparam int CYCLES_PER_WORD = 40;

	logic                           CLK;
	logic                           arst_n = 1'b0;
	logic                           instruction_request;
	logic [`SLURM16_BITS-1:0]       instruction_address;
	logic                           instruction_valid = 1'b0;
	logic [`SLURM16_BITS-1:0]       instruction_data = '0;
	logic                           port_wr;
	logic [`SLURM16_PORT_BITS-1:0]  port_address;
	logic [`SLURM16_BITS-1:0]       port_data;
	logic                           halted;

	logic [31:0]              lfsr = 32'h4a12_d9b4;
	logic [15:0]              program_words [PROG_WORDS];
	logic [23:0]              expected_writes [$];
	logic                     pending;
	logic [`SLURM16_BITS-1:0] pending_addr;
	logic [1:0]               wait_left;
	logic [1:0]               extra_wait;
	int                       cycles_out_of_reset;
	int                       writes_seen;

	slurm16_cpu_top uut (
		.CLK                 (CLK),
		.arst_n              (arst_n),
		.instruction_request (instruction_request),
		.instruction_address (instruction_address),
		.instruction_valid   (instruction_valid),
		.instruction_data    (instruction_data),
		.port_wr             (port_wr),
		.port_address        (port_address),
		.port_data           (port_data),
		.halted              (halted)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic fail_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		stop_with_error($sformatf("FAILED %s expected %0h actual %0h", name, expected, actual));
	endtask

	// fibonacci lfsr with taps 32 22 2 1 and one step per bit
	function automatic logic [7:0] next_bits(input int count);
		logic [7:0] bits;
		logic       fb;
		int         i;
		bits = '0;
		for (i = 0; i < count; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			bits = {bits[6:0], fb};
		end
		return bits;
	endfunction

	// 0..2 wait cycles on top of the one cycle minimum
	function automatic logic [1:0] pick_latency();
		logic [7:0] v;
		v = next_bits(2) % 8'd3;
		return v[1:0];
	endfunction

	function automatic logic [15:0] encode(input slurm16_pkg::opcode_e op,
		input logic [3:0] rd, input logic [7:0] low);
		return {op, rd, low};
	endfunction

	// words outside the program are OUTs whose fields follow the whole address
	function automatic logic [15:0] word_at(input logic [15:0] addr);
		if (addr < PROG_WORDS)
			return program_words[addr];
		else
			return {slurm16_pkg::OP_OUT, addr[15:12] ^ addr[11:8], addr[7:0]};
	endfunction

	task automatic build_program();
		slurm16_pkg::opcode_e op;
		logic [7:0]           sel;
		logic [7:0]           rd;
		logic [7:0]           low;
		int                   i;
		program_words[0]  = encode(slurm16_pkg::OP_MOVI, 4'd1, 8'h05);
		program_words[1]  = encode(slurm16_pkg::OP_MOVI, 4'd2, 8'h03);
		// reads r2 right behind its writer
		program_words[2]  = encode(slurm16_pkg::OP_ADD, 4'd3, 8'h12);
		program_words[3]  = encode(slurm16_pkg::OP_OUT, 4'd3, 8'h10);
		program_words[4]  = encode(slurm16_pkg::OP_SUB, 4'd4, 8'h31);
		program_words[5]  = encode(slurm16_pkg::OP_AND, 4'd5, 8'h42);
		program_words[6]  = encode(slurm16_pkg::OP_OR, 4'd6, 8'h51);
		program_words[7]  = encode(slurm16_pkg::OP_XOR, 4'd7, 8'h66);
		// Z set just before so it is taken to 11
		program_words[8]  = encode(slurm16_pkg::OP_BZ, 4'd0, 8'h02);
		program_words[9]  = encode(slurm16_pkg::OP_OUT, 4'd6, 8'hee);
		program_words[10] = encode(slurm16_pkg::OP_OUT, 4'd7, 8'hef);
		program_words[11] = encode(slurm16_pkg::OP_OUT, 4'd6, 8'h11);
		program_words[12] = encode(slurm16_pkg::OP_ADDI, 4'd1, 8'hff);
		// Z clear so it falls through
		program_words[13] = encode(slurm16_pkg::OP_BZ, 4'd0, 8'h03);
		program_words[14] = encode(slurm16_pkg::OP_OUT, 4'd1, 8'h12);
		program_words[15] = encode(slurm16_pkg::OP_SUB, 4'd8, 8'h21);
		program_words[16] = encode(slurm16_pkg::OP_OUT, 4'd8, 8'h13);
		program_words[17] = encode(slurm16_pkg::OP_JMP, 4'd0, 8'h02);
		program_words[18] = encode(slurm16_pkg::OP_OUT, 4'd1, 8'he0);
		// a flushed HALT must not stop the core
		program_words[19] = encode(slurm16_pkg::OP_HALT, 4'd0, 8'h00);
		program_words[20] = encode(slurm16_pkg::OP_NOP, 4'd0, 8'h00);
		program_words[21] = encode(slurm16_pkg::OP_OUT, 4'd4, 8'h14);
		for (i = FIXED_WORDS; i < FIXED_WORDS + RANDOM_WORDS; i++) begin
			sel = next_bits(3);
			rd = next_bits(4);
			low = next_bits(8);
			case (sel)
				8'd0: op = slurm16_pkg::OP_ADD;
				8'd1: op = slurm16_pkg::OP_SUB;
				8'd2: op = slurm16_pkg::OP_AND;
				8'd3: op = slurm16_pkg::OP_OR;
				8'd4: op = slurm16_pkg::OP_XOR;
				8'd5: op = slurm16_pkg::OP_MOVI;
				default: op = slurm16_pkg::OP_OUT;
			endcase
			program_words[i] = encode(op, rd[3:0], low);
		end
		program_words[PROG_WORDS-1] = encode(slurm16_pkg::OP_HALT, 4'd0, 8'h00);
	endtask

	// runs the program one instruction at a time and queues the port writes
	task automatic run_model();
		logic [15:0]          regs [16];
		logic [15:0]          pc;
		logic [15:0]          word;
		logic [15:0]          a;
		logic [15:0]          b;
		logic [15:0]          sext;
		logic [16:0]          wide;
		logic                 z;
		logic                 c;
		logic                 done;
		int                   steps;
		int                   i;
		slurm16_pkg::opcode_e op;
		for (i = 0; i < 16; i++)
			regs[i] = '0;
		pc = `SLURM16_RESET_PC;
		z = 1'b0;
		c = 1'b0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 1000) begin
			word = word_at(pc);
			op = slurm16_pkg::opcode_e'(word[15:12]);
			a = regs[word[7:4]];
			b = regs[word[3:0]];
			sext = {{8{word[7]}}, word[7:0]};
			wide = '0;
			pc = pc + 16'd1;
			steps++;
			case (op)
				slurm16_pkg::OP_ADD: begin
					wide = {1'b0, a} + {1'b0, b};
					c = wide[16];
				end
				slurm16_pkg::OP_SUB: begin
					wide = {1'b0, a - b};
					c = a >= b;
				end
				slurm16_pkg::OP_AND: wide = {1'b0, a & b};
				slurm16_pkg::OP_OR: wide = {1'b0, a | b};
				slurm16_pkg::OP_XOR: wide = {1'b0, a ^ b};
				slurm16_pkg::OP_ADDI: begin
					wide = {1'b0, regs[word[11:8]]} + {1'b0, sext};
					c = wide[16];
				end
				slurm16_pkg::OP_OUT: expected_writes.push_back({word[7:0], regs[word[11:8]]});
				slurm16_pkg::OP_BZ: if (z) pc = pc + sext;
				slurm16_pkg::OP_JMP: pc = pc + sext;
				slurm16_pkg::OP_HALT: done = 1'b1;
				default: ;
			endcase
			if (op inside {slurm16_pkg::OP_AND, slurm16_pkg::OP_OR, slurm16_pkg::OP_XOR})
				c = 1'b0;
			if (op inside {slurm16_pkg::OP_ADD, slurm16_pkg::OP_SUB, slurm16_pkg::OP_AND,
				slurm16_pkg::OP_OR, slurm16_pkg::OP_XOR, slurm16_pkg::OP_ADDI}) begin
				regs[word[11:8]] = wide[15:0];
				z = wide[15:0] == 16'd0;
			end
			if (op == slurm16_pkg::OP_MOVI)
				regs[word[11:8]] = {8'h00, word[7:0]};
		end
		if (!done)
			stop_with_error("error: the ISA model never reached HALT");
	endtask

	// instruction memory answers each request once after 1 to 3 cycles
	always @(posedge CLK) begin
		instruction_valid <= 1'b0;
		if (!arst_n) begin
			pending <= 1'b0;
		end else begin
			if (pending) begin
				if (wait_left == 2'd0) begin
					instruction_valid <= 1'b1;
					instruction_data <= word_at(pending_addr);
					pending <= 1'b0;
				end else begin
					wait_left <= wait_left - 2'd1;
				end
			end
			if (instruction_request) begin
				extra_wait = pick_latency();
				if (extra_wait == 2'd0) begin
					instruction_valid <= 1'b1;
					instruction_data <= word_at(instruction_address);
				end else begin
					pending <= 1'b1;
					pending_addr <= instruction_address;
					wait_left <= extra_wait - 2'd1;
				end
			end
		end
	end

	task automatic check_port_write();
		logic [23:0] expected;
		if (expected_writes.size() == 0) begin
			stop_with_error($sformatf("error: port write to %0h with no write left in the model",
				port_address));
		end else begin
			expected = expected_writes.pop_front();
			assert (port_address == expected[23:16])
				else fail_value($sformatf("port_address of write %0d", writes_seen),
					expected[23:16], port_address);
			assert (port_data == expected[15:0])
				else fail_value($sformatf("port_data of write %0d", writes_seen),
					expected[15:0], port_data);
			writes_seen++;
		end
	endtask

	// outputs are sampled on the falling edge where they are stable
	always @(negedge CLK) begin
		if (!arst_n) begin
			cycles_out_of_reset = 0;
			assert (!instruction_request && !port_wr && !halted)
				else stop_with_error("error: a strobe or halted is high during reset");
		end else begin
			if (cycles_out_of_reset == 0) begin
				assert (instruction_request)
					else stop_with_error("error: no instruction request right after reset");
				assert (instruction_address == `SLURM16_RESET_PC)
					else fail_value("first_fetch_address", `SLURM16_RESET_PC,
						instruction_address);
			end
			cycles_out_of_reset++;
			if (halted) begin
				assert (!instruction_request)
					else stop_with_error("error: instruction request after halt");
				assert (!port_wr)
					else stop_with_error("error: port write after halt");
			end
			if (port_wr)
				check_port_write();
		end
	end

	initial begin
		repeat (PROG_WORDS * CYCLES_PER_WORD + RESET_CYCLES) @(posedge CLK);
		stop_with_error("error: timeout, the core did not halt in time");
	end

	initial begin
		writes_seen = 0;
		build_program();
		run_model();
		repeat (RESET_CYCLES) @(posedge CLK);
		arst_n <= 1'b1;
		while (!halted)
			@(posedge CLK);
		// a late memory return must not restart anything
		repeat (8) @(posedge CLK);
		if (expected_writes.size() == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			stop_with_error($sformatf("error: %0d expected port writes never appeared",
				expected_writes.size()));
		end
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
slurm16_pkg.sv
slurm16_stage_reg.sv
slurm16_fetch.sv
slurm16_registers.sv
slurm16_decode.sv
slurm16_hazard.sv
slurm16_execute.sv
slurm16_cpu_top.sv
tb_slurm16_cpu.sv
